//--- flist.f
hdl/cpu_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_access_stage.sv
hdl/retire_tracker.sv
hdl/cpu_top.sv
dv/tb_cpu.sv

//--- dv/tb_cpu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cpu;

    // One retirement as seen on the port.
    typedef struct packed {
        cpu_pkg::seq_t     seq;
        cpu_pkg::pc_t      pc;
        logic              we;
        cpu_pkg::reg_idx_t rd;
        cpu_pkg::word_t    data;
        int                lat;  // Fetch to retire, frozen cycles taken out.
    } retire_rec_t;

    // One finished APB transfer.
    typedef struct packed {
        logic           write;
        cpu_pkg::word_t addr;
        cpu_pkg::word_t wdata;
    } apb_xfer_t;

    logic              clk;
    logic              rst_n;
    cpu_pkg::pc_t      imem_addr;
    cpu_pkg::word_t    imem_data;
    cpu_pkg::word_t    paddr;
    logic              pwrite;
    cpu_pkg::word_t    pwdata;
    logic              psel;
    logic              penable;
    cpu_pkg::word_t    prdata;
    logic              pready;
    logic              retire_valid;
    cpu_pkg::seq_t     retire_seq;
    cpu_pkg::pc_t      retire_pc;
    logic              retire_we;
    cpu_pkg::reg_idx_t retire_rd;
    cpu_pkg::word_t    retire_data;
    logic              halted;
    cpu_pkg::word_t    instret;

    cpu_pkg::word_t imem    [256]; // Program, NOP past the end.
    cpu_pkg::word_t apb_mem [256]; // Slave storage.
    cpu_pkg::word_t ref_mem [256]; // Reference view of data memory.
    int             n_instr   = 0;
    int             err_count = 0;

    ////////////////////////////////////////////////////////////////////////////
    // Expected retire values per table entry.
    ////////////////////////////////////////////////////////////////////////////
    logic              exp_we    [64];
    cpu_pkg::reg_idx_t exp_rd    [64];
    cpu_pkg::word_t    exp_data  [64];
    logic              exp_mem   [64]; // LD or ST.
    logic              exp_store [64];
    cpu_pkg::word_t    exp_addr  [64];
    cpu_pkg::word_t    exp_wdata [64];

    retire_rec_t rec_q  [$];
    apb_xfer_t   xfer_q [$];
    retire_rec_t mon_rec;
    apb_xfer_t   mon_xfer;

    int             fetch_cycle [256]; // Cycle in which each address was taken.
    int             fetch_frz   [256];
    int             cycle     = 0;
    int             frz_count = 0;     // Frozen cycles so far.
    logic           frozen;
    int unsigned    delay_tab [64];    // Wait cycles, one per transfer.
    int             n_xfer    = 0;     // Transfers started so far.
    int unsigned    delay;
    int             wait_left;
    cpu_pkg::word_t setup_addr;
    cpu_pkg::word_t setup_wdata;

    cpu_top dut (
        .clk, .rst_n, .imem_addr, .imem_data, .paddr, .pwrite, .pwdata, .psel, .penable,
        .prdata, .pready, .retire_valid, .retire_seq, .retire_pc, .retire_we, .retire_rd,
        .retire_data, .halted, .instret
    );

    assign imem_data = imem[imem_addr]; // Same-cycle instruction port.

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic cpu_pkg::word_t fill_word(input int a);
        return {a[7:0] ^ 8'h5a, ~a[7:0]}; // Every address bit shows.
    endfunction

    function automatic cpu_pkg::word_t sext6(input logic [5:0] v);
        return {{10{v[5]}}, v};
    endfunction

    task automatic add_instr(input cpu_pkg::opcode_t op, input int rd, input int rs,
                             input int imm);
        imem[n_instr] = {op, rd[2:0], rs[2:0], imm[5:0]};
        n_instr++;
    endtask

    task automatic report_mismatch(input string name, input int idx, input logic [15:0] exp,
                                   input logic [15:0] act);
        err_count++;
        $display("error: %s [%0d] expected %h actual %h", name, idx, exp, act);
    endtask

    // Instruction meanings applied to a private register file and memory.
    task automatic run_reference();
        cpu_pkg::word_t    regs [8];
        cpu_pkg::word_t    instr;
        cpu_pkg::word_t    a;
        cpu_pkg::word_t    b;
        cpu_pkg::word_t    res;
        cpu_pkg::word_t    addr;
        cpu_pkg::reg_idx_t rd;
        logic [3:0]        op;
        for (int k = 0; k < 8; k++) regs[k] = '0;
        for (int i = 0; i < n_instr; i++) begin
            instr = imem[i];
            op    = instr[15:12];
            rd    = instr[11:9];
            a     = regs[rd];
            b     = regs[instr[8:6]];           // r0 is never written, stays zero.
            addr  = b + sext6(instr[5:0]);
            res   = '0;
            exp_we[i]    = 1'b1;
            exp_mem[i]   = 1'b0;
            exp_store[i] = 1'b0;
            case (op)
                cpu_pkg::op_add:  res = a + b;
                cpu_pkg::op_sub:  res = a - b;
                cpu_pkg::op_and:  res = a & b;
                cpu_pkg::op_or:   res = a | b;
                cpu_pkg::op_addi: res = a + sext6(instr[5:0]);
                cpu_pkg::op_ld: begin
                    res        = ref_mem[addr[7:0]];
                    exp_mem[i] = 1'b1;
                end
                cpu_pkg::op_st: begin
                    ref_mem[addr[7:0]] = a;
                    exp_mem[i]   = 1'b1;
                    exp_store[i] = 1'b1;
                    exp_we[i]    = 1'b0;
                end
                default: exp_we[i] = 1'b0;      // NOP and HLT.
            endcase
            if (rd == '0) exp_we[i] = 1'b0;
            if (exp_we[i]) regs[rd] = res;
            exp_rd[i]    = rd;
            exp_data[i]  = res;
            exp_addr[i]  = addr;
            exp_wdata[i] = a;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Port monitor, sampled on the rising edge.
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        frozen = psel && !(penable && pready); // Whole pipeline holds.
        if (retire_valid) begin
            mon_rec = {retire_seq, retire_pc, retire_we, retire_rd, retire_data,
                       cycle - fetch_cycle[retire_pc] - (frz_count - fetch_frz[retire_pc])};
            rec_q.push_back(mon_rec);
        end
        if (rst_n && !frozen) begin
            fetch_cycle[imem_addr] = cycle; // Address taken by fetch.
            fetch_frz[imem_addr]   = frz_count;
        end
        if (frozen) frz_count++;
        cycle++;
    end

    // APB slave with 0 to 3 wait cycles per transfer.
    always @(posedge clk) begin
        if (psel) prdata <= apb_mem[paddr[7:0]];
        if (psel && !penable) begin
            delay       = delay_tab[n_xfer % 64];
            n_xfer++;
            wait_left   <= delay;
            pready      <= (delay == 0);
            setup_addr  <= paddr;
            setup_wdata <= pwdata;
        end else if (psel && penable) begin
            if (paddr !== setup_addr || (pwrite && pwdata !== setup_wdata)) begin
                err_count++;
                $display("APB address or write data changed during a transfer");
            end
            if (pready) begin
                if (pwrite) apb_mem[paddr[7:0]] <= pwdata;
                mon_xfer = {pwrite, paddr, pwdata};
                xfer_q.push_back(mon_xfer);
                pready <= 1'b0;
            end else begin
                wait_left <= wait_left - 1;
                pready    <= (wait_left == 1); // Last wait cycle.
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence.
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        int            t;
        logic          aborted;
        logic          late_retire;
        retire_rec_t   rec;
        apb_xfer_t     xf;
        cpu_pkg::seq_t next_seq;
        void'($urandom(74504));
        for (int k = 0; k < 64; k++) delay_tab[k] = $urandom % 4;
        rst_n   = 1'b0;
        pready  = 1'b0;
        prdata  = '0;
        aborted = 1'b0;
        for (int a = 0; a < 256; a++) begin
            imem[a]    = '0;
            apb_mem[a] = fill_word(a);
            ref_mem[a] = fill_word(a);
        end
        // Three slots between a write and its first reader.
        add_instr(cpu_pkg::op_ld,   1, 0, 5);
        add_instr(cpu_pkg::op_ld,   2, 0, 9);
        add_instr(cpu_pkg::op_ld,   3, 0, 12);
        add_instr(cpu_pkg::op_and,  4, 0, 0);   // Clears r4.
        add_instr(cpu_pkg::op_addi, 1, 0, -3);
        add_instr(cpu_pkg::op_addi, 2, 0, 20);
        add_instr(cpu_pkg::op_nop,  0, 0, 0);
        add_instr(cpu_pkg::op_addi, 4, 0, 30);  // Base address.
        add_instr(cpu_pkg::op_sub,  3, 1, 0);
        add_instr(cpu_pkg::op_add,  2, 1, 0);
        add_instr(cpu_pkg::op_and,  5, 0, 0);
        add_instr(cpu_pkg::op_nop,  0, 0, 0);
        add_instr(cpu_pkg::op_st,   3, 4, 2);
        add_instr(cpu_pkg::op_st,   2, 4, 0);
        add_instr(cpu_pkg::op_addi, 5, 0, 7);
        add_instr(cpu_pkg::op_ld,   6, 4, 2);   // Reads back the first store.
        add_instr(cpu_pkg::op_and,  0, 1, 0);   // Write to r0 is dropped.
        add_instr(cpu_pkg::op_nop,  0, 0, 0);
        add_instr(cpu_pkg::op_nop,  0, 0, 0);
        add_instr(cpu_pkg::op_sub,  6, 5, 0);
        add_instr(cpu_pkg::op_ld,   7, 4, 0);
        add_instr(cpu_pkg::op_nop,  0, 0, 0);
        add_instr(cpu_pkg::op_nop,  0, 0, 0);
        add_instr(cpu_pkg::op_nop,  0, 0, 0);
        add_instr(cpu_pkg::op_or,   7, 6, 0);
        add_instr(cpu_pkg::op_st,   6, 4, -1);  // Negative offset.
        add_instr(cpu_pkg::op_hlt,  0, 0, 0);
        run_reference();

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (retire_valid !== 1'b0 || psel !== 1'b0 || penable !== 1'b0 ||
            halted !== 1'b0 || instret !== '0) begin
            err_count++;
            $display("retire, APB or halt outputs not cleared by reset");
        end

        for (int i = 0; i < n_instr && !aborted; i++) begin
            t = 0;
            while (rec_q.size() == 0 && t < 100) begin
                @(negedge clk);
                t++;
            end
            if (rec_q.size() == 0) begin
                err_count++;
                aborted = 1'b1;
                $display("timeout waiting for entry %0d to retire", i);
            end else begin
                rec = rec_q.pop_front();
                if (i > 0 && rec.seq !== next_seq) begin
                    report_mismatch("retire_seq", i, next_seq, rec.seq);
                end
                next_seq = rec.seq + 1'b1;
                if (rec.pc !== i) report_mismatch("retire_pc", i, i, rec.pc);
                if (rec.we !== exp_we[i]) report_mismatch("retire_we", i, exp_we[i], rec.we);
                if (exp_we[i] && rec.rd !== exp_rd[i]) begin
                    report_mismatch("retire_rd", i, exp_rd[i], rec.rd);
                end
                if (exp_we[i] && rec.data !== exp_data[i]) begin
                    report_mismatch("retire_data", i, exp_data[i], rec.data);
                end
                if (rec.lat != 4) report_mismatch("fetch to retire latency", i, 4, rec.lat);
                if (exp_mem[i] && xfer_q.size() == 0) begin
                    err_count++;
                    $display("entry %0d retired without an APB transfer", i);
                end else if (exp_mem[i]) begin
                    xf = xfer_q.pop_front();
                    if (xf.write !== exp_store[i]) begin
                        report_mismatch("pwrite", i, exp_store[i], xf.write);
                    end
                    if (xf.addr !== exp_addr[i]) begin
                        report_mismatch("paddr", i, exp_addr[i], xf.addr);
                    end
                    if (exp_store[i] && xf.wdata !== exp_wdata[i]) begin
                        report_mismatch("pwdata", i, exp_wdata[i], xf.wdata);
                    end
                end
            end
        end

        t = 0;
        while (halted !== 1'b1 && t < 50) begin
            @(negedge clk);
            t++;
        end
        if (halted !== 1'b1) begin
            err_count++;
            $display("halted never went high after HLT");
        end
        // Drained pipeline must stay quiet.
        late_retire = 1'b0;
        for (t = 0; t < 20 && !aborted; t++) begin
            @(negedge clk);
            if (halted !== 1'b1) begin
                err_count++;
                $display("halted dropped after HLT retired");
            end
            if (rec_q.size() != 0) late_retire = 1'b1;
        end
        if (late_retire) begin
            err_count++;
            $display("an instruction retired after HLT");
        end
        if (instret !== n_instr) report_mismatch("instret", 0, n_instr, instret);
        if (xfer_q.size() != 0) begin
            err_count++;
            $display("APB transfers seen with no matching load or store");
        end
        for (int a = 0; a < 256; a++) begin
            if (apb_mem[a] !== ref_mem[a]) begin
                report_mismatch("data memory", a, ref_mem[a], apb_mem[a]);
            end
        end

        $display("%0d entries, %0d errors", n_instr, err_count);
        if (err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/cpu_top.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_top (
    input  wire logic           clk,
    input  wire logic           rst_n,
    output cpu_pkg::pc_t        imem_addr,    // Instruction port.
    input  wire cpu_pkg::word_t imem_data,
    output cpu_pkg::word_t      paddr,        // APB data memory.
    output logic                pwrite,
    output cpu_pkg::word_t      pwdata,
    output logic                psel,
    output logic                penable,
    input  wire cpu_pkg::word_t prdata,
    input  wire logic           pready,
    output logic                retire_valid, // Retire record.
    output cpu_pkg::seq_t       retire_seq,
    output cpu_pkg::pc_t        retire_pc,
    output logic                retire_we,
    output cpu_pkg::reg_idx_t   retire_rd,
    output cpu_pkg::word_t      retire_data,
    output logic                halted,
    output cpu_pkg::word_t      instret
);

    logic stall;

    // Stage to stage.
    logic              f_valid, d_valid, e_valid, m_valid, m_we, wb_we;
    cpu_pkg::pc_t      f_pc, d_pc, e_pc, m_pc;
    cpu_pkg::word_t    f_instr, d_a, d_b, d_imm, e_result, e_store_data, m_data, wb_data;
    cpu_pkg::opcode_t  d_op, e_op, m_op;
    cpu_pkg::reg_idx_t d_rd, e_rd, m_rd, wb_rd;

    fetch_stage u_fetch (
        .clk, .rst_n, .stall, .imem_data, .imem_addr, .f_valid, .f_pc, .f_instr
    );

    decode_stage u_decode (
        .clk, .rst_n, .stall, .f_valid, .f_pc, .f_instr, .wb_we, .wb_rd, .wb_data,
        .d_valid, .d_pc, .d_op, .d_rd, .d_a, .d_b, .d_imm
    );

    execute_stage u_execute (
        .clk, .rst_n, .stall, .d_valid, .d_pc, .d_op, .d_rd, .d_a, .d_b, .d_imm,
        .e_valid, .e_pc, .e_op, .e_rd, .e_result, .e_store_data
    );

    mem_access_stage u_mem (
        .clk, .rst_n, .e_valid, .e_pc, .e_op, .e_rd, .e_result, .e_store_data,
        .prdata, .pready, .stall, .paddr, .pwrite, .pwdata, .psel, .penable,
        .m_valid, .m_pc, .m_op, .m_we, .m_rd, .m_data
    );

    // Write-back and retire bookkeeping.
    retire_tracker u_tracker (
        .clk, .rst_n, .stall, .f_valid, .m_valid, .m_pc, .m_we, .m_rd, .m_data, .m_op,
        .wb_we, .wb_rd, .wb_data, .retire_valid, .retire_seq, .retire_pc, .retire_we,
        .retire_rd, .retire_data, .halted, .instret
    );

endmodule

`default_nettype wire

//--- hdl/retire_tracker.sv
`timescale 1ns/10ps
`default_nettype none

module retire_tracker (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              stall,
    input  wire logic              f_valid,      // New instruction in F.
    input  wire logic              m_valid,
    input  wire cpu_pkg::pc_t      m_pc,
    input  wire logic              m_we,
    input  wire cpu_pkg::reg_idx_t m_rd,
    input  wire cpu_pkg::word_t    m_data,
    input  wire cpu_pkg::opcode_t  m_op,
    output logic                   wb_we,        // Register file write.
    output cpu_pkg::reg_idx_t      wb_rd,
    output cpu_pkg::word_t         wb_data,
    output logic                   retire_valid,
    output cpu_pkg::seq_t          retire_seq,
    output cpu_pkg::pc_t           retire_pc,
    output logic                   retire_we,
    output cpu_pkg::reg_idx_t      retire_rd,
    output cpu_pkg::word_t         retire_data,
    output logic                   halted,
    output cpu_pkg::word_t         instret
);

    cpu_pkg::seq_t next_seq; // Number for the next fetch.
    cpu_pkg::seq_t d_seq;    // Numbers riding alongside D, E and M.
    cpu_pkg::seq_t e_seq;
    cpu_pkg::seq_t m_seq;

    // M holds under stall, so only the unstalled cycle retires.
    assign retire_valid = m_valid && !stall;
    assign retire_seq   = m_seq;
    assign retire_pc    = m_pc;
    assign retire_we    = m_we;
    assign retire_rd    = m_rd;
    assign retire_data  = m_data;

    assign wb_we   = retire_valid && m_we; // Write-back.
    assign wb_rd   = m_rd;
    assign wb_data = m_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            next_seq <= '0;
            d_seq    <= '0;
            e_seq    <= '0;
            m_seq    <= '0;
            halted   <= 1'b0;
            instret  <= '0;
        end else begin
            if (!stall) begin
                if (f_valid) begin
                    d_seq    <= next_seq; // Tagged as F moves into D.
                    next_seq <= next_seq + 1'b1;
                end
                e_seq <= d_seq;
                m_seq <= e_seq;
            end
            if (retire_valid) begin
                instret <= instret + 1'b1;
            end
            if (retire_valid && (m_op == cpu_pkg::op_hlt)) begin
                halted <= 1'b1; // Sticky.
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/mem_access_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem_access_stage (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              e_valid,
    input  wire cpu_pkg::pc_t      e_pc,
    input  wire cpu_pkg::opcode_t  e_op,
    input  wire cpu_pkg::reg_idx_t e_rd,
    input  wire cpu_pkg::word_t    e_result,
    input  wire cpu_pkg::word_t    e_store_data,
    input  wire cpu_pkg::word_t    prdata,
    input  wire logic              pready,
    output logic                   stall,   // Global freeze during a transfer.
    output cpu_pkg::word_t         paddr,
    output logic                   pwrite,
    output cpu_pkg::word_t         pwdata,
    output logic                   psel,
    output logic                   penable,
    output logic                   m_valid,
    output cpu_pkg::pc_t           m_pc,
    output cpu_pkg::opcode_t       m_op,    // Lets the tracker spot HLT.
    output logic                   m_we,
    output cpu_pkg::reg_idx_t      m_rd,
    output cpu_pkg::word_t         m_data
);

    cpu_pkg::apb_phase_t phase;     // Registered, only idle or access.
    cpu_pkg::apb_phase_t cur_phase; // Includes the setup cycle.
    logic                mem_op;    // LD or ST sitting in E.
    logic                writes_rd;

    assign mem_op    = e_valid && ((e_op == cpu_pkg::op_ld) || (e_op == cpu_pkg::op_st));
    assign writes_rd = (e_op inside {cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and,
                                     cpu_pkg::op_or, cpu_pkg::op_addi, cpu_pkg::op_ld});

    ////////////////////////////////////////////////////////////////////////
    // APB requester.
    ////////////////////////////////////////////////////////////////////////
    always_comb begin
        if (phase == cpu_pkg::apb_access) cur_phase = cpu_pkg::apb_access;
        else if (mem_op)                  cur_phase = cpu_pkg::apb_setup; // First cycle.
        else                              cur_phase = cpu_pkg::apb_idle;
    end

    assign psel    = (cur_phase != cpu_pkg::apb_idle);
    assign penable = (cur_phase == cpu_pkg::apb_access);
    assign paddr   = e_result;                  // Held by the E register under stall.
    assign pwdata  = e_store_data;
    assign pwrite  = (e_op == cpu_pkg::op_st);
    assign stall   = (cur_phase == cpu_pkg::apb_setup) ||
                     ((cur_phase == cpu_pkg::apb_access) && !pready); // Released with pready.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= cpu_pkg::apb_idle;
        end else if (cur_phase == cpu_pkg::apb_setup) begin
            phase <= cpu_pkg::apb_access;
        end else if ((cur_phase == cpu_pkg::apb_access) && pready) begin
            phase <= cpu_pkg::apb_idle; // Transfer done.
        end
    end

    // M pipeline register.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m_valid <= 1'b0;
        end else if (!stall) begin
            m_valid <= e_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            m_pc   <= e_pc;
            m_op   <= e_op;
            m_rd   <= e_rd;
            m_we   <= writes_rd && (e_rd != '0); // r0 is never written.
            m_data <= (e_op == cpu_pkg::op_ld) ? prdata : e_result;
        end
    end

endmodule

`default_nettype wire

//--- hdl/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              stall,
    input  wire logic              d_valid,
    input  wire cpu_pkg::pc_t      d_pc,
    input  wire cpu_pkg::opcode_t  d_op,
    input  wire cpu_pkg::reg_idx_t d_rd,
    input  wire cpu_pkg::word_t    d_a,
    input  wire cpu_pkg::word_t    d_b,
    input  wire cpu_pkg::word_t    d_imm,
    output logic                   e_valid,
    output cpu_pkg::pc_t           e_pc,
    output cpu_pkg::opcode_t       e_op,
    output cpu_pkg::reg_idx_t      e_rd,
    output cpu_pkg::word_t         e_result,     // ALU value or memory address.
    output cpu_pkg::word_t         e_store_data  // rd value for ST.
);

    cpu_pkg::word_t alu; // Combinational result.

    always_comb begin
        case (d_op)
            cpu_pkg::op_add:  alu = d_a + d_b;
            cpu_pkg::op_sub:  alu = d_a - d_b;
            cpu_pkg::op_and:  alu = d_a & d_b;
            cpu_pkg::op_or:   alu = d_a | d_b;
            cpu_pkg::op_addi: alu = d_a + d_imm;
            cpu_pkg::op_ld,
            cpu_pkg::op_st:   alu = d_b + d_imm; // Address is rs + imm.
            default:          alu = '0;          // NOP and HLT carry nothing.
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            e_valid <= 1'b0;
        end else if (!stall) begin
            e_valid <= d_valid;
        end
    end

    // Payload.
    always_ff @(posedge clk) begin
        if (!stall) begin
            e_pc         <= d_pc;
            e_op         <= d_op;
            e_rd         <= d_rd;
            e_result     <= alu;
            e_store_data <= d_a;
        end
    end

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              stall,
    input  wire logic              f_valid,
    input  wire cpu_pkg::pc_t      f_pc,
    input  wire cpu_pkg::word_t    f_instr,
    input  wire logic              wb_we,   // Write-back strobe.
    input  wire cpu_pkg::reg_idx_t wb_rd,
    input  wire cpu_pkg::word_t    wb_data,
    output logic                   d_valid,
    output cpu_pkg::pc_t           d_pc,
    output cpu_pkg::opcode_t       d_op,
    output cpu_pkg::reg_idx_t      d_rd,
    output cpu_pkg::word_t         d_a,     // Value of rd.
    output cpu_pkg::word_t         d_b,     // Value of rs.
    output cpu_pkg::word_t         d_imm    // Sign-extended immediate.
);

    cpu_pkg::word_t    regs [cpu_pkg::num_regs]; // Register file.
    cpu_pkg::reg_idx_t rd_idx;
    cpu_pkg::reg_idx_t rs_idx;
    cpu_pkg::imm_t     imm_raw;
    cpu_pkg::word_t    rd_val;
    cpu_pkg::word_t    rs_val;
    cpu_pkg::word_t    imm_ext;

    ////////////////////////////////////////////////////////////////////////
    // Field split and operand read.
    ////////////////////////////////////////////////////////////////////////
    assign rd_idx  = f_instr[cpu_pkg::rd_msb:cpu_pkg::rd_lsb];
    assign rs_idx  = f_instr[cpu_pkg::rs_msb:cpu_pkg::rs_lsb];
    assign imm_raw = f_instr[cpu_pkg::imm_msb:cpu_pkg::imm_lsb];
    assign imm_ext = {{(cpu_pkg::word_w - cpu_pkg::imm_w){imm_raw[cpu_pkg::imm_w-1]}}, imm_raw};

    assign rd_val = (rd_idx == '0) ? '0 : regs[rd_idx]; // r0 is hardwired zero.
    assign rs_val = (rs_idx == '0) ? '0 : regs[rs_idx];

    // Write port, seen by a read one cycle later.
    always_ff @(posedge clk) begin
        if (wb_we && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // D pipeline register.
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            d_valid <= 1'b0;
        end else if (!stall) begin
            d_valid <= f_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            d_pc  <= f_pc;
            d_op  <= cpu_pkg::opcode_t'(f_instr[cpu_pkg::op_msb:cpu_pkg::op_lsb]);
            d_rd  <= rd_idx;
            d_a   <= rd_val;
            d_b   <= rs_val;
            d_imm <= imm_ext;
        end
    end

endmodule

`default_nettype wire

//--- hdl/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage (
    input  wire logic           clk,       // Core clock.
    input  wire logic           rst_n,     // Synchronous reset, active low.
    input  wire logic           stall,     // Pipeline freeze.
    input  wire cpu_pkg::word_t imem_data, // Instruction at imem_addr, same cycle.
    output cpu_pkg::pc_t        imem_addr, // Instruction port address.
    output logic                f_valid,   // F register holds a real instruction.
    output cpu_pkg::pc_t        f_pc,
    output cpu_pkg::word_t      f_instr
);

    cpu_pkg::pc_t pc;      // Address of the next instruction.
    logic         stopped; // HLT already issued.
    logic         is_hlt;  // Instruction on the port is HLT.

    assign imem_addr = pc;
    assign is_hlt    = (imem_data[cpu_pkg::op_msb:cpu_pkg::op_lsb] == cpu_pkg::op_hlt);

    // PC and valid bit.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc      <= '0;
            stopped <= 1'b0;
            f_valid <= 1'b0;
        end else if (!stall) begin
            f_valid <= !stopped; // Bubbles only once halted.
            if (!stopped) begin
                pc      <= pc + 1'b1;
                stopped <= is_hlt; // HLT itself still goes down the pipe.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && !stopped) begin
            f_pc    <= pc;
            f_instr <= imem_data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    ////////////////////////////////////////////////////////////////////////
    // Widths and sizes.
    ////////////////////////////////////////////////////////////////////////
    localparam int word_w   = 16; // Data and instruction word.
    localparam int pc_w     = 8;  // Instruction address.
    localparam int reg_w    = 3;  // Register index.
    localparam int imm_w    = 6;  // Raw immediate field.
    localparam int seq_w    = 8;  // Retire sequence number.
    localparam int num_regs = 8;  // Register file depth, r0 reads zero.

    ////////////////////////////////////////////////////////////////////////
    // Instruction field positions.
    ////////////////////////////////////////////////////////////////////////
    localparam int op_msb  = 15;
    localparam int op_lsb  = 12;
    localparam int rd_msb  = 11; // Destination, also the store source.
    localparam int rd_lsb  = 9;
    localparam int rs_msb  = 8;  // Second operand or address base.
    localparam int rs_lsb  = 6;
    localparam int imm_msb = 5;
    localparam int imm_lsb = 0;

    typedef logic [word_w-1:0] word_t;
    typedef logic [pc_w-1:0]   pc_t;
    typedef logic [reg_w-1:0]  reg_idx_t;
    typedef logic [imm_w-1:0]  imm_t;
    typedef logic [seq_w-1:0]  seq_t;

    // Opcode encodings.
    typedef enum logic [3:0] {
        op_nop  = 4'h0,
        op_add  = 4'h1, // rd = rd + rs.
        op_sub  = 4'h2, // rd = rd - rs.
        op_and  = 4'h3,
        op_or   = 4'h4,
        op_addi = 4'h5, // rd = rd + sext(imm).
        op_ld   = 4'h6, // rd = mem[rs + sext(imm)].
        op_st   = 4'h7, // mem[rs + sext(imm)] = rd.
        op_hlt  = 4'h8  // Stops fetch.
    } opcode_t;

    // APB requester phases.
    typedef enum logic [1:0] {
        apb_idle   = 2'd0,
        apb_setup  = 2'd1,
        apb_access = 2'd2
    } apb_phase_t;

endpackage

`default_nettype wire
